// File: logic/udp_tx_params.svh
`ifndef UDP_TX_PARAMS_SVH
`define UDP_TX_PARAMS_SVH

// ****************************************
// station addresses, fixed at build time
// ****************************************

// locally administered MAC addresses
`define UDP_SRC_MAC 48'h02_1a_2b_3c_4d_01
`define UDP_DST_MAC 48'h02_1a_2b_3c_4d_02

// 192.168.1.10 -> 192.168.1.20
`define UDP_SRC_IP 32'hc0a8_010a
`define UDP_DST_IP 32'hc0a8_0114

`define UDP_SRC_PORT 16'd1234 // source udp port
`define UDP_DST_PORT 16'd5678 // destination udp port

// payload store depth in 32-bit words, power of two
`define UDP_BUF_WORDS 16

// smallest udp payload that still fills a 46-byte ethernet payload
`define UDP_MIN_PAYLOAD 18

`endif

// File: logic/udp_tx_pkg.sv
package udp_tx_pkg;

    // ****************************************
    // protocol constants
    // ****************************************

    localparam logic [15:0] ETH_TYPE_IPV4    = 16'h0800;
    localparam int          IP_UDP_HDR_BYTES = 28; // 20 ip + 8 udp

    // ****************************************
    // wishbone classic
    // ****************************************

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr; // byte address, word aligned
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        REG_CMD    = 4'h0,
        REG_DATA   = 4'h4,
        REG_STATUS = 4'h8
    } wb_reg_e;

    // ****************************************
    // frame description
    // ****************************************

    typedef struct packed {
        logic [15:0] total_len;   // ip total length
        logic [15:0] ident;       // ip identification
        logic [15:0] checksum;    // ip header checksum
        logic [15:0] udp_len;     // udp length field
        logic [15:0] payload_len; // user bytes
    } ip_hdr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_ETH_HEAD,
        ST_IP_HEAD,
        ST_PAYLOAD,
        ST_FCS
    } tx_state_e;

endpackage

// File: logic/udp_wb_regs.sv
`timescale 1ns/1ps

`include "udp_tx_params.svh"

module udp_wb_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  udp_tx_pkg::wb_req_t                  wb_req,
    output udp_tx_pkg::wb_rsp_t                  wb_rsp,
    input  logic                                 tx_done,
    output logic                                 start,
    output logic [15:0]                          payload_len,
    input  logic [$clog2(`UDP_BUF_WORDS)-1:0]    rd_idx,
    output logic [31:0]                          rd_word
);

    localparam int IDX_W = $clog2(`UDP_BUF_WORDS);

    logic [31:0]          buf_mem [`UDP_BUF_WORDS]; // payload words, msb byte first
    logic [IDX_W-1:0]     wr_ptr;
    logic                 ack_q;
    logic [31:0]          rdat_q;
    logic                 busy_q;
    logic [7:0]           frame_cnt;
    logic                 cmd_go;   // command taken, start follows
    logic [15:0]          len_q;

    udp_tx_pkg::wb_reg_e  reg_sel;
    logic                 access;
    logic                 wr_cmd;
    logic                 wr_data;
    logic                 rd_status;

    // ****************************************
    // bus decode
    // ****************************************

    assign reg_sel = udp_tx_pkg::wb_reg_e'(wb_req.adr);

    // one access per ack, master must drop stb in between
    assign access = wb_req.cyc & wb_req.stb & ~ack_q;

    // writes while a frame is out get acked and dropped
    assign wr_cmd  = access & wb_req.we & (reg_sel == udp_tx_pkg::REG_CMD)
                     & wb_req.dat[31] & ~busy_q;
    assign wr_data = access & wb_req.we & (reg_sel == udp_tx_pkg::REG_DATA) & ~busy_q;

    assign rd_status = access & ~wb_req.we & (reg_sel == udp_tx_pkg::REG_STATUS);

    // ****************************************
    // control
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q     <= 1'b0;
            busy_q    <= 1'b0;
            frame_cnt <= 8'd0;
            cmd_go    <= 1'b0;
            start     <= 1'b0;
            wr_ptr    <= '0;
        end else begin
            ack_q  <= access;
            cmd_go <= wr_cmd;
            start  <= cmd_go; // one cycle behind the ack

            if (wr_cmd) begin
                busy_q <= 1'b1;
                wr_ptr <= '0; // next payload loads from word 0
            end else if (wr_data) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            // frame fully on the wire
            if (tx_done) begin
                busy_q    <= 1'b0;
                frame_cnt <= frame_cnt + 8'd1;
            end
        end
    end

    // ****************************************
    // payload store and read data
    // ****************************************

    always_ff @(posedge clk) begin
        if (wr_data)
            buf_mem[wr_ptr] <= wb_req.dat;
        if (wr_cmd)
            len_q <= wb_req.dat[15:0];
        if (access)
            rdat_q <= rd_status ? {busy_q, 23'd0, frame_cnt} : 32'd0;
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

    assign payload_len = len_q;
    assign rd_word     = buf_mem[rd_idx]; // serializer reads without latency

endmodule

// File: logic/ip_header_gen.sv
`timescale 1ns/1ps

`include "udp_tx_params.svh"

module ip_header_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [15:0]         payload_len,
    input  logic                hdr_taken,
    output udp_tx_pkg::ip_hdr_t hdr,
    output logic                hdr_valid
);

    logic [15:0] len_q;
    logic [15:0] total_q;
    logic [15:0] udp_q;
    logic [15:0] ident_q;
    logic [15:0] csum_q;
    logic [19:0] acc_q;   // ten halfwords fit in 20 bits
    logic [2:0]  stage_q; // latched, summed, folded once

    function automatic logic [19:0] ext(input logic [15:0] v);
        return {4'd0, v};
    endfunction

    // ****************************************
    // sequencing
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ident_q   <= 16'd0;
            stage_q   <= 3'd0;
            hdr_valid <= 1'b0;
        end else begin
            stage_q <= {stage_q[1:0], start};
            if (start)
                ident_q <= ident_q + 16'd1; // first frame gets ident 1

            if (stage_q[2])
                hdr_valid <= 1'b1;
            else if (hdr_taken)
                hdr_valid <= 1'b0;
        end
    end

    // ****************************************
    // length fields and checksum pipeline
    // ****************************************

    always_ff @(posedge clk) begin
        if (start) begin
            len_q   <= payload_len;
            total_q <= payload_len + 16'(udp_tx_pkg::IP_UDP_HDR_BYTES);
            udp_q   <= payload_len + 16'd8;
        end

        // checksum field itself counts as zero
        if (stage_q[0])
            acc_q <= ext(16'h4500) + ext(total_q) + ext(ident_q) + ext(16'h4000)
                     + ext(16'h4011)
                     + ext(16'(`UDP_SRC_IP >> 16)) + ext(16'(`UDP_SRC_IP))
                     + ext(16'(`UDP_DST_IP >> 16)) + ext(16'(`UDP_DST_IP));

        if (stage_q[1])
            acc_q <= ext(acc_q[15:0]) + {16'd0, acc_q[19:16]}; // first end-around carry

        // second fold cannot carry again
        if (stage_q[2])
            csum_q <= ~(acc_q[15:0] + {15'd0, acc_q[16]});
    end

    assign hdr = '{
        total_len:   total_q,
        ident:       ident_q,
        checksum:    csum_q,
        udp_len:     udp_q,
        payload_len: len_q
    };

endmodule

// File: logic/eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        crc_en,
    input  logic        crc_clr,
    input  logic [7:0]  crc_din,
    output logic [31:0] crc
);

    localparam logic [31:0] POLY = 32'hedb8_8320; // reflected 0x04c11db7

    // lsb-first update over one byte
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            if (r[0])
                r = (r >> 1) ^ POLY;
            else
                r = r >> 1;
        end
        return r;
    endfunction

    // ****************************************
    // accumulator
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '1;
        end else if (crc_clr) begin
            crc <= '1; // ready for the next frame
        end else if (crc_en) begin
            crc <= crc_byte(crc, crc_din);
        end
    end

endmodule

// File: logic/gmii_frame_tx.sv
`timescale 1ns/1ps

`include "udp_tx_params.svh"

module gmii_frame_tx (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  udp_tx_pkg::ip_hdr_t                  hdr,
    input  logic                                 hdr_valid,
    output logic                                 hdr_taken,
    output logic [$clog2(`UDP_BUF_WORDS)-1:0]    rd_idx,
    input  logic [31:0]                          rd_word,
    input  logic [31:0]                          crc,
    output logic                                 crc_en,
    output logic                                 crc_clr,
    output logic [7:0]                           crc_din,
    output logic                                 gmii_tx_en,
    output logic [7:0]                           gmii_txd,
    output logic                                 tx_done
);

    localparam int IDX_W   = $clog2(`UDP_BUF_WORDS);
    localparam int IP_LAST = udp_tx_pkg::IP_UDP_HDR_BYTES - 1;

    localparam logic [111:0] ETH_HEAD = {`UDP_DST_MAC, `UDP_SRC_MAC, udp_tx_pkg::ETH_TYPE_IPV4};

    udp_tx_pkg::tx_state_e state_q;
    udp_tx_pkg::tx_state_e follow_st; // section after the current one

    logic [15:0] cnt_q;     // byte index inside the section
    logic [15:0] pay_bytes; // payload plus padding
    logic [8*udp_tx_pkg::IP_UDP_HDR_BYTES-1:0] ip_head;
    logic [31:0] fcs;
    logic [7:0]  pay_byte;
    logic [7:0]  nxt_byte;
    logic        nxt_en;
    logic        last_byte;

    // ****************************************
    // byte sources
    // ****************************************

    assign ip_head = {8'h45, 8'h00, hdr.total_len, hdr.ident, 16'h4000, 8'h40, 8'd17,
                      hdr.checksum, `UDP_SRC_IP, `UDP_DST_IP, `UDP_SRC_PORT,
                      `UDP_DST_PORT, hdr.udp_len, 16'h0000};

    assign pay_bytes = (hdr.payload_len < 16'(`UDP_MIN_PAYLOAD)) ?
                       16'(`UDP_MIN_PAYLOAD) : hdr.payload_len;

    assign rd_idx   = cnt_q[IDX_W+1:2];
    assign pay_byte = rd_word[8 * (3 - cnt_q[1:0]) +: 8]; // msb first
    assign fcs      = ~crc;

    // byte for the next gmii cycle, crc sees it on the same edge
    always_comb begin
        nxt_en    = 1'b1;
        nxt_byte  = 8'h00;
        crc_en    = 1'b0;
        last_byte = 1'b0;
        follow_st = state_q;
        case (state_q)
            udp_tx_pkg::ST_PREAMBLE: begin
                nxt_byte  = (cnt_q[2:0] == 3'd7) ? 8'hd5 : 8'h55; // sfd closes it
                last_byte = (cnt_q == 16'd7);
                follow_st = udp_tx_pkg::ST_ETH_HEAD;
            end
            udp_tx_pkg::ST_ETH_HEAD: begin
                nxt_byte  = ETH_HEAD[8 * (13 - cnt_q[3:0]) +: 8];
                crc_en    = 1'b1;
                last_byte = (cnt_q == 16'd13);
                follow_st = udp_tx_pkg::ST_IP_HEAD;
            end
            udp_tx_pkg::ST_IP_HEAD: begin
                nxt_byte  = ip_head[8 * (IP_LAST - cnt_q[4:0]) +: 8];
                crc_en    = 1'b1;
                last_byte = (cnt_q == 16'(IP_LAST));
                follow_st = udp_tx_pkg::ST_PAYLOAD;
            end
            udp_tx_pkg::ST_PAYLOAD: begin
                nxt_byte  = (cnt_q < hdr.payload_len) ? pay_byte : 8'h00; // zero pad
                crc_en    = 1'b1;
                last_byte = (cnt_q == pay_bytes - 16'd1);
                follow_st = udp_tx_pkg::ST_FCS;
            end
            udp_tx_pkg::ST_FCS: begin
                nxt_byte  = fcs[8 * cnt_q[1:0] +: 8]; // low byte first
                last_byte = (cnt_q == 16'd3);
                follow_st = udp_tx_pkg::ST_IDLE;
            end
            default: begin
                nxt_en = 1'b0;
            end
        endcase
    end

    assign crc_din = nxt_byte;
    assign crc_clr = tx_done;

    // ****************************************
    // frame FSM
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= udp_tx_pkg::ST_IDLE;
            cnt_q     <= 16'd0;
            hdr_taken <= 1'b0;
        end else begin
            hdr_taken <= 1'b0;
            if (state_q == udp_tx_pkg::ST_IDLE) begin
                cnt_q <= 16'd0;
                if (hdr_valid) begin
                    state_q   <= udp_tx_pkg::ST_PREAMBLE;
                    hdr_taken <= 1'b1;
                end
            end else if (last_byte) begin
                state_q <= follow_st;
                cnt_q   <= 16'd0;
            end else begin
                cnt_q <= cnt_q + 16'd1;
            end
        end
    end

    // ****************************************
    // gmii output register
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'h00;
            tx_done    <= 1'b0;
        end else begin
            gmii_tx_en <= nxt_en;
            gmii_txd   <= nxt_byte;
            tx_done    <= gmii_tx_en & ~nxt_en; // last fcs byte just left
        end
    end

endmodule

// File: logic/udp_gmii_tx.sv
`timescale 1ns/1ps

`include "udp_tx_params.svh"

module udp_gmii_tx (
    input  logic                clk,
    input  logic                rst_n,
    input  udp_tx_pkg::wb_req_t wb_req,
    output udp_tx_pkg::wb_rsp_t wb_rsp,
    output logic                gmii_tx_en,
    output logic [7:0]          gmii_txd,
    output logic                tx_done
);

    logic                                 start;
    logic [15:0]                          payload_len;
    logic [$clog2(`UDP_BUF_WORDS)-1:0]    rd_idx;
    logic [31:0]                          rd_word;
    udp_tx_pkg::ip_hdr_t                  hdr;
    logic                                 hdr_valid;
    logic                                 hdr_taken;
    logic [31:0]                          crc;
    logic                                 crc_en;
    logic                                 crc_clr;
    logic [7:0]                           crc_din;

    udp_wb_regs u_udp_wb_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .tx_done     (tx_done),
        .start       (start),
        .payload_len (payload_len),
        .rd_idx      (rd_idx),
        .rd_word     (rd_word)
    );

    ip_header_gen u_ip_header_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .payload_len (payload_len),
        .hdr_taken   (hdr_taken),
        .hdr         (hdr),
        .hdr_valid   (hdr_valid)
    );

    eth_crc32 u_eth_crc32 (
        .clk     (clk),
        .rst_n   (rst_n),
        .crc_en  (crc_en),
        .crc_clr (crc_clr),
        .crc_din (crc_din),
        .crc     (crc)
    );

    gmii_frame_tx u_gmii_frame_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr        (hdr),
        .hdr_valid  (hdr_valid),
        .hdr_taken  (hdr_taken),
        .rd_idx     (rd_idx),
        .rd_word    (rd_word),
        .crc        (crc),
        .crc_en     (crc_en),
        .crc_clr    (crc_clr),
        .crc_din    (crc_din),
        .gmii_tx_en (gmii_tx_en),
        .gmii_txd   (gmii_txd),
        .tx_done    (tx_done)
    );

endmodule

// File: verif/udp_gmii_tx_checker.sv
`timescale 1ns/1ps

`include "udp_tx_params.svh"

module udp_gmii_tx_checker (
    input logic                clk,
    input logic                rst_n,
    input udp_tx_pkg::wb_req_t wb_req,
    input udp_tx_pkg::wb_rsp_t wb_rsp,
    input logic                gmii_tx_en,
    input logic                tx_done
);

    // shortest frame on the wire, payload padded to the minimum
    localparam int MIN_FRAME = 8 + 14 + udp_tx_pkg::IP_UDP_HDR_BYTES + `UDP_MIN_PAYLOAD + 4;

    int unsigned fail_cnt = 0;
    int unsigned en_run;   // cycles tx_en has been high in this burst

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            en_run <= 0;
        else if (gmii_tx_en)
            en_run <= en_run + 1;
        else
            en_run <= 0;
    end

    // ****************************************
    // wishbone classic handshake
    // ****************************************

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            $error("ack without cyc and stb in the previous cycle");
            fail_cnt++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack held for more than one cycle");
            fail_cnt++;
        end

    // ****************************************
    // gmii side
    // ****************************************

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done |=> !tx_done)
        else begin
            $error("tx_done longer than one cycle");
            fail_cnt++;
        end

    // a gap would split a frame into a burst shorter than any frame
    no_gap: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gmii_tx_en) |-> en_run >= MIN_FRAME)
        else begin
            $error("gmii_tx_en dropped inside a frame");
            fail_cnt++;
        end

endmodule

bind udp_gmii_tx udp_gmii_tx_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .gmii_tx_en (gmii_tx_en),
    .tx_done    (tx_done)
);

// File: verif/udp_gmii_tx_tb.sv
`timescale 1ns/1ps

`include "udp_tx_params.svh"

module udp_gmii_tx_tb;

    localparam int CLK_PERIOD = 100; // ns
    localparam int NUM_ROWS   = 5;

    typedef struct packed {
        logic [15:0] len;   // payload bytes
        logic [31:0] pseed; // mixed into the random seed
        logic        mid;   // extra writes while the frame is out
    } row_t;

    // frames go out in table order, so idents run 1..5
    row_t rows [NUM_ROWS] = '{
        '{16'd5,  32'h0000_0005, 1'b0},
        '{16'd40, 32'h0000_1040, 1'b0},
        '{16'd24, 32'h0000_2024, 1'b1},
        '{16'd18, 32'h0000_3018, 1'b0},
        '{16'd64, 32'h0000_4064, 1'b0}
    };

    logic                clk;
    logic                rst_n;
    udp_tx_pkg::wb_req_t wb_req;
    udp_tx_pkg::wb_rsp_t wb_rsp;
    logic                gmii_tx_en;
    logic [7:0]          gmii_txd;
    logic                tx_done;

    logic [7:0]  pay [64];
    logic [7:0]  exp_q [$];   // reference frame
    logic [7:0]  rx_q [$];    // bytes seen on gmii
    integer      seed        = 32'h3bd5_a77e;
    int          errs        = 0;
    int          passes      = 0;
    int          fails       = 0;
    int          frames_seen = 0;
    logic        in_frame    = 1'b0;
    logic [15:0] next_ident  = 16'd1;
    int unsigned cyc_cnt     = 0;
    int unsigned ack_cyc;
    int unsigned start_cyc;

    udp_gmii_tx u_udp_gmii_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .gmii_tx_en (gmii_tx_en),
        .gmii_txd   (gmii_txd),
        .tx_done    (tx_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

    // ****************************************
    // gmii collector, samples mid cycle
    // ****************************************

    always @(negedge clk) begin
        if (gmii_tx_en) begin
            if (!in_frame)
                start_cyc = cyc_cnt;
            in_frame = 1'b1;
            rx_q.push_back(gmii_txd);
        end else if (in_frame) begin
            in_frame = 1'b0;
            assert (tx_done) else begin
                $display("tx_done did not follow the last frame byte");
                errs++;
            end
            frames_seen++;
        end
    end

    // ****************************************
    // wishbone driver
    // ****************************************

    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_rsp.ack);
        rdat       = wb_rsp.dat;
        ack_cyc    = cyc_cnt; // cycle that carried the ack
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic read_reg(input logic [3:0] adr, output logic [31:0] rdat);
        bus_cycle(1'b0, adr, 32'd0, rdat);
    endtask

    // ****************************************
    // reference frame model
    // ****************************************

    function automatic int frame_len(input int n);
        return 8 + 14 + 28 + ((n < `UDP_MIN_PAYLOAD) ? `UDP_MIN_PAYLOAD : n) + 4;
    endfunction

    // bitwise ethernet crc, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c;
        for (int k = 0; k < 8; k++)
            r = (r >> 1) ^ (((r[0] ^ b[k]) == 1'b1) ? 32'hedb8_8320 : 32'h0);
        return r;
    endfunction

    // ones-complement sum over the ten halfwords of the queued ip header
    function automatic logic [15:0] ip_checksum(input int first);
        logic [31:0] sum;
        sum = 32'd0;
        for (int i = first; i < first + 20; i += 2)
            sum += {16'd0, exp_q[i], exp_q[i+1]};
        while (sum[31:16] != 16'd0)
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        return ~sum[15:0];
    endfunction

    task automatic push_field(input logic [63:0] v, input int nb);
        for (int i = nb - 1; i >= 0; i--)
            exp_q.push_back(v[8*i +: 8]); // network order
    endtask

    task automatic build_frame(input int n, input logic [15:0] ident);
        logic [31:0] c;
        logic [15:0] tl;
        logic [15:0] ul;
        logic [15:0] cs;
        tl = 16'(n + 28);
        ul = 16'(n + 8);
        exp_q.delete();
        repeat (7) exp_q.push_back(8'h55);
        exp_q.push_back(8'hd5);
        push_field(`UDP_DST_MAC, 6);
        push_field(`UDP_SRC_MAC, 6);
        push_field(64'h0800, 2);
        push_field(64'h4500, 2);
        push_field(tl, 2);
        push_field(ident, 2);
        push_field(64'h4000_4011, 4); // flags, ttl, protocol
        push_field(64'h0, 2);         // checksum, filled in below
        push_field(`UDP_SRC_IP, 4);
        push_field(`UDP_DST_IP, 4);
        cs = ip_checksum(22);         // ip header follows preamble and mac header
        exp_q[32] = cs[15:8];
        exp_q[33] = cs[7:0];
        push_field(`UDP_SRC_PORT, 2);
        push_field(`UDP_DST_PORT, 2);
        push_field(ul, 2);
        push_field(64'h0, 2);
        for (int i = 0; i < n; i++)
            exp_q.push_back(pay[i]);
        for (int i = n; i < `UDP_MIN_PAYLOAD; i++)
            exp_q.push_back(8'h00);
        c = 32'hffff_ffff;
        for (int i = 8; i < exp_q.size(); i++)
            c = crc_step(c, exp_q[i]);
        c = ~c;
        for (int i = 0; i < 4; i++)
            exp_q.push_back(c[8*i +: 8]);
    endtask

    // ****************************************
    // test steps
    // ****************************************

    task automatic load_payload(input int n);
        for (int w = 0; w < (n + 3) / 4; w++)
            write_reg(udp_tx_pkg::REG_DATA, {pay[4*w], pay[4*w+1], pay[4*w+2], pay[4*w+3]});
    endtask

    task automatic check_frame(input int n, input int unsigned cmd_cyc);
        assert (start_cyc - cmd_cyc == 7) else begin
            $display("gmii_tx_en rose %0d cycles after the command ack instead of 7",
                     start_cyc - cmd_cyc);
            errs++;
        end
        assert (rx_q.size() == frame_len(n)) else begin
            $display("frame is %0d bytes long, expected %0d", rx_q.size(), frame_len(n));
            errs++;
        end
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++)
            assert (rx_q[i] == exp_q[i]) else begin
                $display("Mismatch gmii_txd byte %0d: got %02h expected %02h",
                         i, rx_q[i], exp_q[i]);
                errs++;
            end
    endtask

    task automatic report_test(input int idx, input int len, input int mark);
        if (errs == mark) begin
            passes++;
            $display("test %0d (%0d bytes): ok", idx, len);
        end else begin
            fails++;
            $display("test %0d (%0d bytes): %0d errors", idx, len, errs - mark);
        end
    endtask

    task automatic run_row(input int r);
        row_t        row;
        int          mark;
        int          base;
        int unsigned cmd_cyc;
        logic [31:0] st;
        row  = rows[r];
        mark = errs;
        seed = seed ^ row.pseed;
        for (int i = 0; i < 64; i++) begin
            if (i < row.len)
                pay[i] = 8'($random(seed));
            else
                pay[i] = 8'h00;
        end
        load_payload(row.len);
        base = frames_seen;
        rx_q.delete();
        write_reg(udp_tx_pkg::REG_CMD, {16'h8000, row.len});
        cmd_cyc = ack_cyc;
        build_frame(row.len, next_ident);
        if (row.mid) begin
            wait (in_frame);
            read_reg(udp_tx_pkg::REG_STATUS, st);
            assert (st[31]) else begin
                $display("status busy bit low while a frame is on the wire");
                errs++;
            end
            // all of these must be dropped
            write_reg(udp_tx_pkg::REG_DATA, 32'hdead_beef);
            write_reg(udp_tx_pkg::REG_DATA, 32'h0bad_f00d);
            write_reg(udp_tx_pkg::REG_CMD, 32'h8000_0028);
        end
        wait (frames_seen != base);
        check_frame(row.len, cmd_cyc);
        if (row.mid) begin
            repeat (20) @(posedge clk);
            assert (frames_seen == base + 1 && !gmii_tx_en) else begin
                $display("a command written while busy started another frame");
                errs++;
            end
        end
        next_ident++;
        read_reg(udp_tx_pkg::REG_STATUS, st);
        assert (st == {24'd0, 8'(r + 1)}) else begin
            $display("Mismatch status: got %08h expected %08h", st, {24'd0, 8'(r + 1)});
            errs++;
        end
        report_test(r + 1, row.len, mark);
    endtask

    // ****************************************
    // main sequence
    // ****************************************

    initial begin
        logic [31:0] st;
        int          mark;
        int          chk_fails;
        wb_req = '0;
        rst_n  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        mark = errs;
        assert (!gmii_tx_en && !tx_done) else begin
            $display("gmii_tx_en or tx_done high after reset");
            errs++;
        end
        read_reg(udp_tx_pkg::REG_STATUS, st);
        assert (st == 32'd0) else begin
            $display("Mismatch status: got %08h expected %08h", st, 32'd0);
            errs++;
        end
        report_test(0, 0, mark);

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);

        chk_fails = u_udp_gmii_tx.u_checker.fail_cnt;
        if (chk_fails != 0) begin
            $display("bound checker: %0d assertion failures", chk_fails);
            fails++;
        end
        $display("%0d tests passed, %0d tests failed", passes, fails);
        if (fails == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // budget is twice the frame time plus slack per row
    initial begin
        int unsigned wd_cycles;
        wd_cycles = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            wd_cycles += 2 * (frame_len(rows[r].len) + 20);
        #(wd_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles with tests still running", wd_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: udp_gmii_tx.f
+incdir+logic
logic/udp_tx_pkg.sv
logic/udp_wb_regs.sv
logic/ip_header_gen.sv
logic/eth_crc32.sv
logic/gmii_frame_tx.sv
logic/udp_gmii_tx.sv
verif/udp_gmii_tx_checker.sv
verif/udp_gmii_tx_tb.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= udp_gmii_tx_tb
FILELIST ?= udp_gmii_tx.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log
SIMARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
